// ==== tb/conStimInput.txt ====
# id cond(octal) magic(octal) ebusIn[18:24] ctl diagSel ebusOut[18:24] flags
# ctl = eboxSync consoleControl userMode publicMode diagRead
# flags = ebusDrive condAdr10 run start conoApr conoPi conoPag delayReq
1 00 000 0000000 00000 0 0000000 00000000
1 00 000 0000000 00001 0 0000000 10000000
1 00 000 0000000 00001 1 0000000 10000000
1 00 000 0000000 00001 2 0000000 10000000
1 00 000 0000000 00001 3 0000000 10000000
1 00 000 0000000 00001 4 0000000 10000000
1 00 000 0000000 00001 5 0000000 10000000
1 00 000 0000000 00001 6 0000000 10000000
1 00 000 0000000 00001 7 0000000 10000000
2 20 016 1101100 00000 0 0000000 00000010
2 20 015 1010000 10001 0 1101000 10000100
2 20 015 0101010 00001 0 1101101 10000000
2 20 014 0000000 10001 0 1101101 10001000
2 20 016 0000000 01001 0 1101101 10000000
2 20 040 0000000 00001 0 1101101 10000001
2 20 016 0000000 00001 0 1101101 10000010
2 00 000 0000000 00001 0 0010101 10000000
3 15 322 0000000 00001 2 0000000 10000000
3 16 013 0000000 00001 2 1110100 10000000
3 00 000 0000000 00001 3 1011000 10000000
4 21 210 0000000 00001 1 0000000 10000000
4 21 143 0000000 00001 1 1010000 10000000
4 21 304 0000000 00001 1 0111000 10000000
4 00 777 0000000 00001 1 1101000 10000000
4 00 000 0000000 00001 1 1101000 10000000
5 20 011 0000000 00001 4 0000000 10000000
5 20 012 0000000 00001 4 0000000 10000000
5 70 000 0000000 00001 4 0000000 11000000
5 71 000 0000000 00001 4 1000000 11100000
5 70 000 0000000 00001 4 1100000 10110000
5 20 010 0000000 00001 4 1000000 10100000
5 20 011 0000000 01001 4 1000000 10100000
5 71 000 0000000 00001 4 1000000 11100000
5 71 000 0000000 00001 4 0000000 10000000
5 71 000 0000000 00001 4 0000000 10000000
6 60 000 0000000 00000 0 0000000 01000000
6 60 000 0000000 00100 0 0000000 00000000
6 61 000 0000000 00100 0 0000000 01000000
6 62 000 0000000 00010 0 0000000 01000000
6 62 000 0000000 00100 0 0000000 00000000
6 63 000 0000000 00000 0 0000000 01000000
6 64 000 0000000 00000 0 0000000 00000000
6 72 000 0000000 00000 0 0000000 01000000
6 73 000 0000000 00000 0 0000000 01000000
6 15 010 0000000 00000 0 0000000 00000000
6 72 000 0000000 00000 0 0000000 00000000
6 73 000 0000000 00000 0 0000000 00000000
6 63 000 0000000 00000 0 0000000 00000000
6 77 000 0000000 00000 0 0000000 00000000
6 35 000 0000000 00000 0 0000000 00000000
6 70 000 0000000 00000 0 0000000 01000000

// ==== verilog.f ====
source/conPkg.sv
source/conMicroDecode.sv
source/conRunControl.sv
source/conStateRegs.sv
source/conStatusSelect.sv
source/conBoard.sv
tb/conChecker.sv
tb/conBoardTb.sv

// ==== Makefile ====
TOOL       = verilator
FILELIST   = verilog.f
TOP        = conBoardTb
RTL_TOP    = conBoard
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_LINE  = Result: PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_LINE)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/conBoardTb.sv ====
`timescale 1ns/100ps

module conBoardTb;

  localparam int    maxRecords = 256;
  localparam int    fieldCount = 8;
  localparam string stimFile   = "tb/conStimInput.txt";

  logic                              conCLK;
  logic                              CLK;
  logic [0:conPkg::condWidth-1]      cramCond;
  logic [0:conPkg::magicWidth-1]     cramMagic;
  logic [conPkg::ebusFieldWidth-1:0] ebusIn;
  logic                              eboxSync;
  logic                              consoleControl;
  logic                              userMode;
  logic                              publicMode;
  logic                              diagRead;
  logic [conPkg::diagSelWidth-1:0]   diagSel;
  logic [conPkg::ebusFieldWidth-1:0] ebusOut;
  logic                              ebusDrive;
  logic                              condAdr10;
  logic                              run;
  logic                              start;
  logic                              conoApr;
  logic                              conoPi;
  logic                              conoPag;
  logic                              delayReq;

  logic       checkEn;
  int         testId;
  int         step;
  logic [6:0] expEbusOut;
  logic [7:0] expFlags;
  int         mismatchCount;

  // Loaded records, inputs and expected outputs packed per step
  int          recCount;
  int          recId  [maxRecords];
  logic [29:0] recIn  [maxRecords];
  logic [14:0] recExp [maxRecords];
  int          otherErrors;
  int          cycleLimit;
  int          cycleCount = 0;

  conBoard #(
    .runSyncStages (3)
  ) conBoard_i (
    .conCLK         (conCLK),
    .CLK            (CLK),
    .cramCond       (cramCond),
    .cramMagic      (cramMagic),
    .ebusIn         (ebusIn),
    .eboxSync       (eboxSync),
    .consoleControl (consoleControl),
    .userMode       (userMode),
    .publicMode     (publicMode),
    .diagRead       (diagRead),
    .diagSel        (diagSel),
    .ebusOut        (ebusOut),
    .ebusDrive      (ebusDrive),
    .condAdr10      (condAdr10),
    .run            (run),
    .start          (start),
    .conoApr        (conoApr),
    .conoPi         (conoPi),
    .conoPag        (conoPag),
    .delayReq       (delayReq)
  );

  conChecker conChecker_i (
    .conCLK        (conCLK),
    .checkEn       (checkEn),
    .testId        (testId),
    .step          (step),
    .expEbusOut    (expEbusOut),
    .expFlags      (expFlags),
    .ebusOut       (ebusOut),
    .ebusDrive     (ebusDrive),
    .condAdr10     (condAdr10),
    .run           (run),
    .start         (start),
    .conoApr       (conoApr),
    .conoPi        (conoPi),
    .conoPag       (conoPag),
    .delayReq      (delayReq),
    .mismatchCount (mismatchCount)
  );

  initial begin
    conCLK = 1'b0;
    forever begin
      #50 conCLK = ~conCLK;
    end
  end

  task automatic loadRecords();
    int         fd;
    int         lineNo;
    int         fields;
    string      line;
    int         tId;
    logic [5:0] tCond;
    logic [8:0] tMagic;
    logic [6:0] tEbus;
    logic [4:0] tCtl;
    logic [2:0] tSel;
    logic [6:0] tOut;
    logic [7:0] tFlags;
    fd = $fopen(stimFile, "r");
    if (fd == 0) begin
      $display("Error: stimulus file %s could not be opened", stimFile);
      otherErrors++;
      return;
    end
    lineNo = 0;
    while ($fgets(line, fd) != 0) begin
      lineNo++;
      // Comment and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%d %o %o %b %b %d %b %b",
                       tId, tCond, tMagic, tEbus, tCtl, tSel, tOut, tFlags);
      if (fields != fieldCount) begin
        $display("Error: line %0d of %s is malformed", lineNo, stimFile);
        otherErrors++;
      end else if (recCount >= maxRecords) begin
        $display("Error: %s holds more records than the testbench can store", stimFile);
        otherErrors++;
      end else begin
        recId[recCount]  = tId;
        recIn[recCount]  = {tCond, tMagic, tEbus, tCtl, tSel};
        recExp[recCount] = {tOut, tFlags};
        recCount++;
      end
    end
    $fclose(fd);
    if (recCount == 0) begin
      $display("Error: %s holds no records", stimFile);
      otherErrors++;
    end
  endtask

  task automatic applyRecord(input int k);
    {cramCond, cramMagic, ebusIn, eboxSync, consoleControl, userMode, publicMode,
     diagRead, diagSel} = recIn[k];
    {expEbusOut, expFlags} = recExp[k];
    testId  = recId[k];
    step    = k;
    checkEn = 1'b1;
  endtask

  initial begin
    CLK            = 1'b1;
    cramCond       = '0;
    cramMagic      = '0;
    ebusIn         = '0;
    eboxSync       = 1'b0;
    consoleControl = 1'b0;
    userMode       = 1'b0;
    publicMode     = 1'b0;
    diagRead       = 1'b0;
    diagSel        = '0;
    checkEn        = 1'b0;
    testId         = 0;
    step           = 0;
    expEbusOut     = '0;
    expFlags       = '0;
    recCount       = 0;
    otherErrors    = 0;
    loadRecords();
    cycleLimit = recCount + 20;
    repeat (5) @(posedge conCLK);
    @(negedge conCLK);
    CLK = 1'b0;
    for (int k = 0; k < recCount; k++) begin
      applyRecord(k);
      @(negedge conCLK);
    end
    checkEn = 1'b0;
    @(posedge conCLK);
    $display("Errors: %0d value mismatches, %0d other errors", mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge conCLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Error: timeout, the run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

// ==== tb/conChecker.sv ====
`timescale 1ns/100ps

module conChecker (
  input  logic       conCLK,
  input  logic       checkEn,
  input  int         testId,
  input  int         step,
  input  logic [6:0] expEbusOut,
  input  logic [7:0] expFlags,
  input  logic [6:0] ebusOut,
  input  logic       ebusDrive,
  input  logic       condAdr10,
  input  logic       run,
  input  logic       start,
  input  logic       conoApr,
  input  logic       conoPi,
  input  logic       conoPag,
  input  logic       delayReq,
  output int         mismatchCount
);

  int mismatches = 0;

  assign mismatchCount = mismatches;

  function automatic string testName(input int id);
    case (id)
      1:       return "resetValues";
      2:       return "conoPagPi";
      3:       return "specLatchSr";
      4:       return "stateFlags";
      5:       return "runStart";
      6:       return "skipSelect";
      default: return "unknown";
    endcase
  endfunction

  task automatic compareBit(input string field, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Fail test %s step %0d: %s expected %b actual %b",
               testName(testId), step, field, expected, actual);
    end
  endtask

  // Sampled at the rising edge, before any register moves
  always @(posedge conCLK) begin
    if (checkEn) begin
      if (ebusOut !== expEbusOut) begin
        mismatches++;
        $display("Fail test %s step %0d: ebusOut expected %b actual %b",
                 testName(testId), step, expEbusOut, ebusOut);
      end
      compareBit("ebusDrive", expFlags[7], ebusDrive);
      compareBit("condAdr10", expFlags[6], condAdr10);
      compareBit("run", expFlags[5], run);
      compareBit("start", expFlags[4], start);
      compareBit("conoApr", expFlags[3], conoApr);
      compareBit("conoPi", expFlags[2], conoPi);
      compareBit("conoPag", expFlags[1], conoPag);
      compareBit("delayReq", expFlags[0], delayReq);
    end
  end

endmodule

// ==== source/conBoard.sv ====
`timescale 1ns/100ps

module conBoard #(
  parameter int runSyncStages = 3
) (
  input  logic                          conCLK,
  input  logic                          CLK,
  input  logic [0:conPkg::condWidth-1]  cramCond,
  input  logic [0:conPkg::magicWidth-1] cramMagic,
  input  logic [conPkg::ebusFirstBit:conPkg::ebusFirstBit+conPkg::ebusFieldWidth-1] ebusIn,
  input  logic                          eboxSync,
  input  logic                          consoleControl,
  input  logic                          userMode,
  input  logic                          publicMode,
  input  logic                          diagRead,
  input  logic [conPkg::diagSelWidth-1:0] diagSel,
  output logic [conPkg::ebusFirstBit:conPkg::ebusFirstBit+conPkg::ebusFieldWidth-1] ebusOut,
  output logic                          ebusDrive,
  output logic                          condAdr10,
  output logic                          run,
  output logic                          start,
  output logic                          conoApr,
  output logic                          conoPi,
  output logic                          conoPag,
  output logic                          delayReq
);

  logic       loadSpecInstr;
  logic       srLoad;
  logic       stateLoad;
  logic       setRun;
  logic       clrRun;
  logic       contPulse;
  logic       cacheLookEn;
  logic       cacheLoadEn;
  logic       trapEn;
  logic       kiPagingMode;
  logic       wrEvenParAdr;
  logic       wrEvenParData;
  logic       wrEvenParDir;
  logic       kernelCycle;
  logic       pcPlus1Inh;
  logic       pxct;
  logic       intDisable;
  logic       eboxHalted;
  logic [0:3] ucodeState;
  logic [0:3] sr;

  conMicroDecode conMicroDecode_i (
    .cramCond       (cramCond),
    .cramMagic      (cramMagic),
    .eboxSync       (eboxSync),
    .consoleControl (consoleControl),
    .loadSpecInstr  (loadSpecInstr),
    .srLoad         (srLoad),
    .stateLoad      (stateLoad),
    .setRun         (setRun),
    .clrRun         (clrRun),
    .contPulse      (contPulse),
    .conoApr        (conoApr),
    .conoPi         (conoPi),
    .conoPag        (conoPag),
    .delayReq       (delayReq)
  );

  conRunControl #(
    .runSyncStages (runSyncStages)
  ) conRunControl_i (
    .conCLK    (conCLK),
    .CLK       (CLK),
    .setRun    (setRun),
    .clrRun    (clrRun),
    .contPulse (contPulse),
    .run       (run),
    .start     (start)
  );

  conStateRegs conStateRegs_i (
    .conCLK        (conCLK),
    .CLK           (CLK),
    .cramMagic     (cramMagic),
    .ebusIn        (ebusIn),
    .loadSpecInstr (loadSpecInstr),
    .srLoad        (srLoad),
    .stateLoad     (stateLoad),
    .conoPi        (conoPi),
    .conoPag       (conoPag),
    .cacheLookEn   (cacheLookEn),
    .cacheLoadEn   (cacheLoadEn),
    .trapEn        (trapEn),
    .kiPagingMode  (kiPagingMode),
    .wrEvenParAdr  (wrEvenParAdr),
    .wrEvenParData (wrEvenParData),
    .wrEvenParDir  (wrEvenParDir),
    .kernelCycle   (kernelCycle),
    .pcPlus1Inh    (pcPlus1Inh),
    .pxct          (pxct),
    .intDisable    (intDisable),
    .eboxHalted    (eboxHalted),
    .ucodeState    (ucodeState),
    .sr            (sr)
  );

  conStatusSelect conStatusSelect_i (
    .cramCond      (cramCond),
    .run           (run),
    .start         (start),
    .userMode      (userMode),
    .publicMode    (publicMode),
    .pxct          (pxct),
    .intDisable    (intDisable),
    .cacheLookEn   (cacheLookEn),
    .cacheLoadEn   (cacheLoadEn),
    .trapEn        (trapEn),
    .kiPagingMode  (kiPagingMode),
    .wrEvenParAdr  (wrEvenParAdr),
    .wrEvenParData (wrEvenParData),
    .wrEvenParDir  (wrEvenParDir),
    .kernelCycle   (kernelCycle),
    .pcPlus1Inh    (pcPlus1Inh),
    .eboxHalted    (eboxHalted),
    .ucodeState    (ucodeState),
    .sr            (sr),
    .diagRead      (diagRead),
    .diagSel       (diagSel),
    .condAdr10     (condAdr10),
    .ebusOut       (ebusOut),
    .ebusDrive     (ebusDrive)
  );

endmodule

// ==== source/conStatusSelect.sv ====
`timescale 1ns/100ps

module conStatusSelect (
  input  logic [0:conPkg::condWidth-1]  cramCond,
  input  logic                          run,
  input  logic                          start,
  input  logic                          userMode,
  input  logic                          publicMode,
  input  logic                          pxct,
  input  logic                          intDisable,
  input  logic                          cacheLookEn,
  input  logic                          cacheLoadEn,
  input  logic                          trapEn,
  input  logic                          kiPagingMode,
  input  logic                          wrEvenParAdr,
  input  logic                          wrEvenParData,
  input  logic                          wrEvenParDir,
  input  logic                          kernelCycle,
  input  logic                          pcPlus1Inh,
  input  logic                          eboxHalted,
  input  logic [0:3]                    ucodeState,
  input  logic [0:3]                    sr,
  input  logic                          diagRead,
  input  logic [conPkg::diagSelWidth-1:0] diagSel,
  output logic                          condAdr10,
  output logic [conPkg::ebusFirstBit:conPkg::ebusFirstBit+conPkg::ebusFieldWidth-1] ebusOut,
  output logic                          ebusDrive
);

  logic [2:0] condGroup;
  logic [2:0] skipSel;
  logic       kernelMode;
  logic [0:7] skip6xBits;
  logic [0:7] skip7xBits;

  assign condGroup  = cramCond[0:2];
  assign skipSel    = cramCond[3:5];
  assign kernelMode = !userMode && !publicMode;

  // Skip conditions indexed by COND bits 3..5
  assign skip6xBits = {kernelMode, userMode, publicMode, kernelCycle, 4'b0000};
  assign skip7xBits = {!start, run, pxct, !intDisable, 4'b0000};

  always_comb begin
    case (condGroup)
      conPkg::condSkip6x: condAdr10 = skip6xBits[skipSel];
      conPkg::condSkip7x: condAdr10 = skip7xBits[skipSel];
      default:            condAdr10 = 1'b0;
    endcase
  end

  assign ebusDrive = diagRead;

  // Words are packed from bit 18 down
  always_comb begin
    ebusOut = '0;
    if (diagRead) begin
      case (diagSel)
        conPkg::diagEnables:   ebusOut = {cacheLookEn, cacheLoadEn, kiPagingMode, trapEn,
                                          wrEvenParAdr, wrEvenParData, wrEvenParDir};
        conPkg::diagState:     ebusOut = {ucodeState, 3'b000};
        conPkg::diagSpecLatch: ebusOut = {kernelCycle, pcPlus1Inh, pxct, intDisable,
                                          eboxHalted, 2'b00};
        conPkg::diagSrWord:    ebusOut = {sr, 3'b000};
        conPkg::diagRunWord:   ebusOut = {run, start, 5'b00000};
        default:               ebusOut = '0;
      endcase
    end
  end

endmodule

// ==== source/conStateRegs.sv ====
`timescale 1ns/100ps

module conStateRegs (
  input  logic                          conCLK,
  input  logic                          CLK,
  input  logic [0:conPkg::magicWidth-1] cramMagic,
  input  logic [conPkg::ebusFirstBit:conPkg::ebusFirstBit+conPkg::ebusFieldWidth-1] ebusIn,
  input  logic                          loadSpecInstr,
  input  logic                          srLoad,
  input  logic                          stateLoad,
  input  logic                          conoPi,
  input  logic                          conoPag,
  output logic                          cacheLookEn,
  output logic                          cacheLoadEn,
  output logic                          trapEn,
  output logic                          kiPagingMode,
  output logic                          wrEvenParAdr,
  output logic                          wrEvenParData,
  output logic                          wrEvenParDir,
  output logic                          kernelCycle,
  output logic                          pcPlus1Inh,
  output logic                          pxct,
  output logic                          intDisable,
  output logic                          eboxHalted,
  output logic [0:3]                    ucodeState,
  output logic [0:3]                    sr
);

  // CONO PI, write-even-parity controls
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      wrEvenParAdr  <= 1'b0;
      wrEvenParData <= 1'b0;
      wrEvenParDir  <= 1'b0;
    end else if (conoPi) begin
      wrEvenParAdr  <= ebusIn[18];
      wrEvenParData <= ebusIn[19];
      wrEvenParDir  <= ebusIn[20];
    end
  end

  // CONO PAG; line 21 is the KL paging enable, stored inverted
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      cacheLookEn  <= 1'b0;
      cacheLoadEn  <= 1'b0;
      kiPagingMode <= 1'b0;
      trapEn       <= 1'b0;
    end else if (conoPag) begin
      cacheLookEn  <= ebusIn[18];
      cacheLoadEn  <= ebusIn[19];
      kiPagingMode <= !ebusIn[21];
      trapEn       <= ebusIn[22];
    end
  end

  // Special-instruction latch
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      kernelCycle <= 1'b0;
      pcPlus1Inh  <= 1'b0;
      pxct        <= 1'b0;
      intDisable  <= 1'b0;
      eboxHalted  <= 1'b0;
    end else if (loadSpecInstr) begin
      kernelCycle <= cramMagic[1];
      pcPlus1Inh  <= cramMagic[2];
      pxct        <= cramMagic[4];
      intDisable  <= cramMagic[5];
      eboxHalted  <= cramMagic[7];
    end
  end

  // Odd MAGIC bit sets a flag, the even bit after it clears
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      ucodeState <= '0;
    end else if (stateLoad) begin
      for (int i = 0; i < 4; i++) begin
        ucodeState[i] <= cramMagic[2*i+1] || (ucodeState[i] && !cramMagic[2*i+2]);
      end
    end
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      sr <= '0;
    end else if (srLoad) begin
      sr <= cramMagic[5:8];
    end
  end

endmodule

// ==== source/conRunControl.sv ====
`timescale 1ns/100ps

module conRunControl #(
  parameter int runSyncStages = 3
) (
  input  logic conCLK,
  input  logic CLK,
  input  logic setRun,
  input  logic clrRun,
  input  logic contPulse,
  output logic run,
  output logic start
);

  // Stage 0 of runChain is the run request flag itself
  logic [runSyncStages-1:0] runChain;
  logic [runSyncStages-1:0] startChain;
  logic                     runReqNext;

  // Clear beats set
  assign runReqNext = !clrRun && (setRun || runChain[0]);

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runChain   <= '0;
      startChain <= '0;
    end else begin
      runChain[0]   <= runReqNext;
      startChain[0] <= contPulse;
      for (int i = 1; i < runSyncStages; i++) begin
        runChain[i]   <= runChain[i-1];
        startChain[i] <= startChain[i-1];
      end
    end
  end

  assign run   = runChain[runSyncStages-1];
  assign start = startChain[runSyncStages-1];

endmodule

// ==== source/conMicroDecode.sv ====
`timescale 1ns/100ps

module conMicroDecode (
  input  logic [0:conPkg::condWidth-1]  cramCond,
  input  logic [0:conPkg::magicWidth-1] cramMagic,
  input  logic                          eboxSync,
  input  logic                          consoleControl,
  output logic                          loadSpecInstr,
  output logic                          srLoad,
  output logic                          stateLoad,
  output logic                          setRun,
  output logic                          clrRun,
  output logic                          contPulse,
  output logic                          conoApr,
  output logic                          conoPi,
  output logic                          conoPag,
  output logic                          delayReq
);

  logic [2:0] condGroup;
  logic [2:0] condSub;
  logic [2:0] magicGroup;
  logic [2:0] magicSel;
  logic       condEn10;
  logic       condEn20;
  logic       condDiagFunc;
  logic       diagCtlEn;

  assign condGroup  = cramCond[0:2];
  assign condSub    = cramCond[3:5];
  assign magicGroup = cramMagic[3:5];
  assign magicSel   = cramMagic[6:8];

  assign condEn10 = (condGroup == conPkg::condGroup10);
  assign condEn20 = (condGroup == conPkg::condGroup20);

  // Group 10 and group 20 strobes
  assign loadSpecInstr = condEn10 && (condSub == conPkg::cond10SpecInstr);
  assign srLoad        = condEn10 && (condSub == conPkg::cond10SrMagic);
  assign condDiagFunc  = condEn20 && (condSub == conPkg::cond20DiagFunc);
  assign stateLoad     = condEn20 && (condSub == conPkg::cond20EboxState);

  assign delayReq = condDiagFunc & cramMagic[3];

  // 01x functions are locked out while the console has control
  assign diagCtlEn = condDiagFunc && !cramMagic[2] && !consoleControl &&
                     (magicGroup == conPkg::magicGroupDiag);

  assign clrRun    = diagCtlEn && (magicSel == conPkg::magicClrRun);
  assign setRun    = diagCtlEn && (magicSel == conPkg::magicSetRun);
  assign contPulse = diagCtlEn && (magicSel == conPkg::magicContinue);

  // APR and PI only take CONO in sync with the EBOX
  assign conoApr = diagCtlEn && eboxSync && (magicSel == conPkg::magicConoApr);
  assign conoPi  = diagCtlEn && eboxSync && (magicSel == conPkg::magicConoPi);
  assign conoPag = diagCtlEn && (magicSel == conPkg::magicConoPag);

endmodule

// ==== source/conPkg.sv ====
package conPkg;

  // Microword and EBUS field widths
  localparam int condWidth      = 6;
  localparam int magicWidth     = 9;
  localparam int ebusFieldWidth = 7;
  localparam int ebusFirstBit   = 18;
  localparam int diagSelWidth   = 3;

  // COND groups, upper three bits
  localparam logic [2:0] condGroup10 = 3'd1;
  localparam logic [2:0] condGroup20 = 3'd2;
  localparam logic [2:0] condGroup30 = 3'd3;
  localparam logic [2:0] condSkip6x  = 3'd6;
  localparam logic [2:0] condSkip7x  = 3'd7;

  // Group 10 subfields
  localparam logic [2:0] cond10LoadIr    = 3'd4;
  localparam logic [2:0] cond10SpecInstr = 3'd5;
  localparam logic [2:0] cond10SrMagic   = 3'd6;

  // Group 20 subfields
  localparam logic [2:0] cond20DiagFunc  = 3'd0;
  localparam logic [2:0] cond20EboxState = 3'd1;

  // MAGIC bits 3..5 for the 01x diagnostic group, then bits 6..8
  localparam logic [2:0] magicGroupDiag = 3'd1;
  localparam logic [2:0] magicClrRun    = 3'd0;
  localparam logic [2:0] magicSetRun    = 3'd1;
  localparam logic [2:0] magicContinue  = 3'd2;
  localparam logic [2:0] magicConoApr   = 3'd4;
  localparam logic [2:0] magicConoPi    = 3'd5;
  localparam logic [2:0] magicConoPag   = 3'd6;

  // Readback words
  localparam logic [diagSelWidth-1:0] diagEnables   = 3'd0;
  localparam logic [diagSelWidth-1:0] diagState     = 3'd1;
  localparam logic [diagSelWidth-1:0] diagSpecLatch = 3'd2;
  localparam logic [diagSelWidth-1:0] diagSrWord    = 3'd3;
  localparam logic [diagSelWidth-1:0] diagRunWord   = 3'd4;

endpackage
